/* rtl/dmem_pkg.sv */
`default_nettype none

package dmem_pkg;

  // CPU side address and data word
  localparam int DMEM_AW = 32;
  localparam int DMEM_DW = 32;

  // One strobe per byte lane
  localparam int DMEM_SW = DMEM_DW / 8;

  // Address bit 31 set means I/O region, clear means cached region
  localparam int IO_SEL_BIT = 31;

  // Direct-mapped cache, one word per line
  localparam int CACHE_LINES = 16;
  localparam int CACHE_IDX_W = 4;

  // Index sits at addr[5:2], tag takes everything above it
  localparam int CACHE_TAG_W = DMEM_AW - CACHE_IDX_W - 2;

  // Backing RAM behind the cache
  localparam int RAM_DEPTH = 1024;
  localparam int RAM_AW    = 10;

  // I/O region RAM
  localparam int IO_DEPTH = 64;
  localparam int IO_AW    = 6;

  // Cycles from mem_ren to mem_rvalid
  localparam int MISS_LATENCY = 4;

endpackage

`default_nettype wire

/* rtl/dmem_io_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_io_ram (
  input  logic                          clk,
  input  logic                          io_ren,
  input  logic [dmem_pkg::DMEM_AW-1:0]  io_raddr,
  output logic [dmem_pkg::DMEM_DW-1:0]  io_rdata,
  input  logic                          io_wen,
  input  logic [dmem_pkg::DMEM_AW-1:0]  io_waddr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  io_wdata,
  input  logic [dmem_pkg::DMEM_SW-1:0]  io_wstrb
);

  import dmem_pkg::*;

  logic [DMEM_DW-1:0] mem_q [IO_DEPTH];

  // BRAM style, data out the cycle after io_ren
  always_ff @(posedge clk) begin
    if (io_ren) begin
      io_rdata <= mem_q[io_raddr[IO_AW+1:2]];
    end
    if (io_wen) begin
      for (int b = 0; b < DMEM_SW; b++) begin
        if (io_wstrb[b]) begin
          mem_q[io_waddr[IO_AW+1:2]][8*b +: 8] <= io_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/dmem_backing_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_backing_ram (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          mem_ren,
  input  logic [dmem_pkg::RAM_AW-1:0]   mem_raddr,
  output logic [dmem_pkg::DMEM_DW-1:0]  mem_rdata,
  output logic                          mem_rvalid,
  input  logic                          mem_we,
  input  logic [dmem_pkg::RAM_AW-1:0]   mem_waddr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  mem_wdata,
  input  logic [dmem_pkg::DMEM_SW-1:0]  mem_wstrb
);

  import dmem_pkg::*;

  logic [DMEM_DW-1:0]      mem_q [RAM_DEPTH];
  logic [DMEM_DW-1:0]      data_pipe [MISS_LATENCY];
  logic [MISS_LATENCY-1:0] valid_pipe;

  // Byte-strobed write, lands at the end of the mem_we cycle
  always_ff @(posedge clk) begin
    if (mem_we) begin
      for (int b = 0; b < DMEM_SW; b++) begin
        if (mem_wstrb[b]) begin
          mem_q[mem_waddr][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data enters stage 0 and walks the pipe
  always_ff @(posedge clk) begin
    data_pipe[0] <= mem_q[mem_raddr];
    for (int i = 1; i < MISS_LATENCY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // Valid marker travels with its data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[MISS_LATENCY-2:0], mem_ren};
    end
  end

  assign mem_rdata  = data_pipe[MISS_LATENCY-1];
  assign mem_rvalid = valid_pipe[MISS_LATENCY-1];

endmodule

`default_nettype wire

/* rtl/dmem_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_cache (
  input  logic                          clk,
  input  logic                          rst_n,

  // Request side from the bridge
  input  logic                          cache_rd_valid,
  output logic                          cache_rd_ready,
  input  logic [dmem_pkg::DMEM_AW-1:0]  cache_rd_addr,
  output logic [dmem_pkg::DMEM_DW-1:0]  cache_rd_data,
  output logic                          cache_rd_data_valid,
  input  logic                          cache_wr_valid,
  output logic                          cache_wr_ready,
  input  logic [dmem_pkg::DMEM_AW-1:0]  cache_wr_addr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  cache_wr_data,
  input  logic [dmem_pkg::DMEM_SW-1:0]  cache_wr_strb,

  // Backing RAM side
  output logic                          mem_ren,
  output logic [dmem_pkg::RAM_AW-1:0]   mem_raddr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  mem_rdata,
  input  logic                          mem_rvalid,
  output logic                          mem_we,
  output logic [dmem_pkg::RAM_AW-1:0]   mem_waddr,
  output logic [dmem_pkg::DMEM_DW-1:0]  mem_wdata,
  output logic [dmem_pkg::DMEM_SW-1:0]  mem_wstrb
);

  import dmem_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_MISS_WAIT,
    ST_RESPOND
  } state_t;

  state_t                 state;
  state_t                 state_next;

  // Line storage
  logic [DMEM_DW-1:0]     data_q [CACHE_LINES];
  logic [CACHE_TAG_W-1:0] tag_q  [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid_q;

  logic [CACHE_IDX_W-1:0] rd_idx;
  logic [CACHE_IDX_W-1:0] wr_idx;
  logic [CACHE_TAG_W-1:0] rd_tag;
  logic [CACHE_TAG_W-1:0] wr_tag;
  logic                   rd_hit;
  logic                   wr_hit;
  logic                   rd_accept;
  logic                   wr_accept;
  logic                   fill;
  logic                   resp_wr;

  // Index from addr[5:2], tag from the bits above
  assign rd_idx = cache_rd_addr[CACHE_IDX_W+1:2];
  assign rd_tag = cache_rd_addr[DMEM_AW-1:CACHE_IDX_W+2];
  assign wr_idx = cache_wr_addr[CACHE_IDX_W+1:2];
  assign wr_tag = cache_wr_addr[DMEM_AW-1:CACHE_IDX_W+2];

  assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  // Tag compare happens on the cycle a request is accepted
  assign rd_accept = (state == ST_IDLE) && cache_rd_valid;
  assign wr_accept = (state == ST_IDLE) && cache_wr_valid && !cache_rd_valid;
  assign fill      = (state == ST_MISS_WAIT) && mem_rvalid;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (rd_accept) begin
          state_next = rd_hit ? ST_LOOKUP : ST_MISS_WAIT;
        end else if (wr_accept) begin
          state_next = ST_RESPOND;
        end
      end
      // Hit line is read straight out of the array
      ST_LOOKUP:    state_next = ST_IDLE;
      ST_MISS_WAIT: begin
        if (mem_rvalid) begin
          state_next = ST_RESPOND;
        end
      end
      ST_RESPOND:   state_next = ST_IDLE;
      default:      state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      resp_wr <= 1'b0;
      valid_q <= '0;
    end else begin
      state <= state_next;
      // RESPOND serves both a filled read and a write ack
      if (state == ST_IDLE) begin
        resp_wr <= wr_accept;
      end
      if (fill) begin
        valid_q[rd_idx] <= 1'b1;
      end
    end
  end

  // Fill on miss return; write hit merges only the strobed lanes
  always_ff @(posedge clk) begin
    if (fill) begin
      data_q[rd_idx] <= mem_rdata;
      tag_q[rd_idx]  <= rd_tag;
    end else if (wr_accept && wr_hit) begin
      for (int b = 0; b < DMEM_SW; b++) begin
        if (cache_wr_strb[b]) begin
          data_q[wr_idx][8*b +: 8] <= cache_wr_data[8*b +: 8];
        end
      end
    end
  end

  // Backing read only on a miss, one-cycle pulse from IDLE
  assign mem_ren   = rd_accept && !rd_hit;
  assign mem_raddr = cache_rd_addr[RAM_AW+1:2];

  // Write-through, every write goes out, no allocate on miss
  assign mem_we    = wr_accept;
  assign mem_waddr = cache_wr_addr[RAM_AW+1:2];
  assign mem_wdata = cache_wr_data;
  assign mem_wstrb = cache_wr_strb;

  assign cache_rd_ready      = (state == ST_IDLE);
  assign cache_rd_data       = data_q[rd_idx];
  assign cache_rd_data_valid = (state == ST_LOOKUP) ||
                               ((state == ST_RESPOND) && !resp_wr);
  assign cache_wr_ready      = (state == ST_RESPOND) && resp_wr;

endmodule

`default_nettype wire

/* rtl/dmem_cache_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_cache_bridge (
  input  logic                          clk,
  input  logic                          rst_n,

  // CPU data port
  input  logic                          dmem_ren,
  input  logic [dmem_pkg::DMEM_AW-1:0]  dmem_raddr,
  output logic [dmem_pkg::DMEM_DW-1:0]  dmem_rdata,
  input  logic                          dmem_we,
  input  logic [dmem_pkg::DMEM_AW-1:0]  dmem_waddr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  dmem_wdata,
  input  logic [dmem_pkg::DMEM_SW-1:0]  dmem_wstrb,
  output logic                          dmem_stall,

  // Cache request side
  output logic                          cache_rd_valid,
  input  logic                          cache_rd_ready,
  output logic [dmem_pkg::DMEM_AW-1:0]  cache_rd_addr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  cache_rd_data,
  input  logic                          cache_rd_data_valid,
  output logic                          cache_wr_valid,
  input  logic                          cache_wr_ready,
  output logic [dmem_pkg::DMEM_AW-1:0]  cache_wr_addr,
  output logic [dmem_pkg::DMEM_DW-1:0]  cache_wr_data,
  output logic [dmem_pkg::DMEM_SW-1:0]  cache_wr_strb,

  // I/O bypass side
  output logic                          io_ren,
  output logic [dmem_pkg::DMEM_AW-1:0]  io_raddr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  io_rdata,
  output logic                          io_wen,
  output logic [dmem_pkg::DMEM_AW-1:0]  io_waddr,
  output logic [dmem_pkg::DMEM_DW-1:0]  io_wdata,
  output logic [dmem_pkg::DMEM_SW-1:0]  io_wstrb
);

  import dmem_pkg::*;

  logic                 io_sel_rd;
  logic                 io_sel_wr;
  logic                 io_sel_rd_q;
  logic                 rd_pending;
  logic                 wr_pending;
  logic                 busy;
  logic                 rd_start;
  logic                 wr_start;
  logic [DMEM_AW-1:0]   rd_addr_q;
  logic [DMEM_AW-1:0]   wr_addr_q;
  logic [DMEM_DW-1:0]   wr_data_q;
  logic [DMEM_SW-1:0]   wr_strb_q;

  // Region decode on the raw CPU addresses
  assign io_sel_rd = dmem_raddr[IO_SEL_BIT];
  assign io_sel_wr = dmem_waddr[IO_SEL_BIT];

  // New cache requests are dropped while one is outstanding
  assign busy     = rd_pending || wr_pending;
  assign rd_start = dmem_ren && !io_sel_rd && !busy;
  assign wr_start = dmem_we && !io_sel_wr && !busy;

  // Pending flags, set by the CPU pulse and cleared by the cache answer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pending  <= 1'b0;
      wr_pending  <= 1'b0;
      io_sel_rd_q <= 1'b0;
    end else begin
      if (rd_start) begin
        rd_pending <= 1'b1;
      end else if (cache_rd_data_valid) begin
        rd_pending <= 1'b0;
      end
      if (wr_start) begin
        wr_pending <= 1'b1;
      end else if (cache_wr_ready) begin
        wr_pending <= 1'b0;
      end
      // Remember where the last read went, steers the read mux
      if (dmem_ren) begin
        io_sel_rd_q <= io_sel_rd;
      end
    end
  end

  // Capture the request, the CPU is free to move its buses afterwards
  always_ff @(posedge clk) begin
    if (rd_start) begin
      rd_addr_q <= dmem_raddr;
    end
    if (wr_start) begin
      wr_addr_q <= dmem_waddr;
      wr_data_q <= dmem_wdata;
      wr_strb_q <= dmem_wstrb;
    end
  end

  // Valid follows the pending flag and is held until answered
  assign cache_rd_valid = rd_pending;
  assign cache_rd_addr  = rd_addr_q;
  assign cache_wr_valid = wr_pending;
  assign cache_wr_addr  = wr_addr_q;
  assign cache_wr_data  = wr_data_q;
  assign cache_wr_strb  = wr_strb_q;

  // Cache takes any request while idle and the CPU never overlaps requests,
  // so cache_rd_ready carries no information this side needs

  // I/O region bypasses the cache with the CPU pulse as is
  assign io_ren   = dmem_ren && io_sel_rd;
  assign io_raddr = dmem_raddr;
  assign io_wen   = dmem_we && io_sel_wr;
  assign io_waddr = dmem_waddr;
  assign io_wdata = dmem_wdata;
  assign io_wstrb = dmem_wstrb;

  // I/O data lands one cycle after the pulse, cache data on data_valid
  assign dmem_rdata = io_sel_rd_q ? io_rdata : cache_rd_data;

  // Hold the CPU until the cache answers the outstanding request
  assign dmem_stall = (rd_pending && !cache_rd_data_valid) ||
                      (wr_pending && !cache_wr_ready);

endmodule

`default_nettype wire

/* rtl/dmem_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_subsystem_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          dmem_ren,
  input  logic [dmem_pkg::DMEM_AW-1:0]  dmem_raddr,
  output logic [dmem_pkg::DMEM_DW-1:0]  dmem_rdata,
  input  logic                          dmem_we,
  input  logic [dmem_pkg::DMEM_AW-1:0]  dmem_waddr,
  input  logic [dmem_pkg::DMEM_DW-1:0]  dmem_wdata,
  input  logic [dmem_pkg::DMEM_SW-1:0]  dmem_wstrb,
  output logic                          dmem_stall
);

  import dmem_pkg::*;

  // Bridge to cache
  logic               cache_rd_valid;
  logic               cache_rd_ready;
  logic [DMEM_AW-1:0] cache_rd_addr;
  logic [DMEM_DW-1:0] cache_rd_data;
  logic               cache_rd_data_valid;
  logic               cache_wr_valid;
  logic               cache_wr_ready;
  logic [DMEM_AW-1:0] cache_wr_addr;
  logic [DMEM_DW-1:0] cache_wr_data;
  logic [DMEM_SW-1:0] cache_wr_strb;

  // Cache to backing RAM
  logic               mem_ren;
  logic [RAM_AW-1:0]  mem_raddr;
  logic [DMEM_DW-1:0] mem_rdata;
  logic               mem_rvalid;
  logic               mem_we;
  logic [RAM_AW-1:0]  mem_waddr;
  logic [DMEM_DW-1:0] mem_wdata;
  logic [DMEM_SW-1:0] mem_wstrb;

  // Bridge to I/O RAM
  logic               io_ren;
  logic [DMEM_AW-1:0] io_raddr;
  logic [DMEM_DW-1:0] io_rdata;
  logic               io_wen;
  logic [DMEM_AW-1:0] io_waddr;
  logic [DMEM_DW-1:0] io_wdata;
  logic [DMEM_SW-1:0] io_wstrb;

  // Port names match the nets one to one
  dmem_cache_bridge dmem_cache_bridge_i (.*);

  dmem_cache dmem_cache_i (.*);

  dmem_backing_ram dmem_backing_ram_i (.*);

  dmem_io_ram dmem_io_ram_i (.*);

endmodule

`default_nettype wire

/* dv/dmem_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dmem_subsystem_tb;

  import dmem_pkg::*;

  // Operation count per test: io 6, write/read 3, partial 5, evict 8, random 200
  localparam int NUM_OPS        = 6 + 3 + 5 + 8 + 200;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (MISS_LATENCY + 4) + 200;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               dmem_ren;
  logic [DMEM_AW-1:0] dmem_raddr;
  logic [DMEM_DW-1:0] dmem_rdata;
  logic               dmem_we;
  logic [DMEM_AW-1:0] dmem_waddr;
  logic [DMEM_DW-1:0] dmem_wdata;
  logic [DMEM_SW-1:0] dmem_wstrb;
  logic               dmem_stall;

  // Reference state, one memory per region plus a copy of the cache tags
  logic [31:0] io_mem  [logic [31:0]];
  logic [31:0] ram_mem [logic [31:0]];
  logic [25:0] ref_tag [16];
  logic [15:0] ref_valid = '0;

  // Completed operations waiting for the compare process
  logic [31:0] exp_data_q[$];
  logic [31:0] got_data_q[$];
  int          exp_stall_q[$];
  int          got_stall_q[$];
  bit          is_read_q[$];
  logic [31:0] addr_q[$];

  logic [31:0] cmp_addr;
  logic [31:0] cmp_exp_data;
  logic [31:0] cmp_got_data;
  int          cmp_exp_stall;
  int          cmp_got_stall;
  bit          cmp_is_read;

  logic [31:0] rng_state   = 32'd70778;
  int          errors      = 0;
  int          checks      = 0;
  int          errs_mark   = 0;
  int          cycle_count = 0;

  dmem_subsystem_top dmem_subsystem_top_i (.*);

  // 8 ns clock
  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // True once a word has a defined value in its region
  function automatic bit is_known(input logic [31:0] a);
    if (a[31]) begin
      return io_mem.exists(a) != 0;
    end
    return ram_mem.exists(a) != 0;
  endfunction

  // Expected read word and stall cycles of one access, updates the model
  function automatic int ref_access(input bit wr, input logic [31:0] a,
                                    input logic [31:0] wdata, input logic [3:0] strb,
                                    output logic [31:0] word);
    logic [31:0] cur;
    logic [3:0]  idx;
    logic [25:0] tag;
    int          stalls;
    idx    = a[5:2];
    tag    = a[31:6];
    cur    = 32'h0;
    stalls = 0;
    if (a[31]) begin
      // I/O bypass never stalls
      if (io_mem.exists(a)) cur = io_mem[a];
    end else begin
      if (ram_mem.exists(a)) cur = ram_mem[a];
      if (wr) begin
        // Write-through, no allocate, tags untouched
        stalls = 1;
      end else if (ref_valid[idx] && ref_tag[idx] == tag) begin
        stalls = 1;
      end else begin
        stalls         = MISS_LATENCY + 1;
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
      end
    end
    if (wr) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) cur[8*b +: 8] = wdata[8*b +: 8];
      end
      if (a[31]) io_mem[a] = cur;
      else ram_mem[a] = cur;
    end
    word = cur;
    return stalls;
  endfunction

  // One CPU pulse, wait out the stall, then leave an idle cycle
  task automatic do_access(input bit wr, input logic [31:0] a,
                           input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] exp_word;
    int          exp_stall;
    int          stalls;
    @(posedge clk);
    if (wr) begin
      dmem_we    <= 1'b1;
      dmem_waddr <= a;
      dmem_wdata <= wdata;
      dmem_wstrb <= strb;
    end else begin
      dmem_ren   <= 1'b1;
      dmem_raddr <= a;
    end
    @(posedge clk);
    dmem_we  <= 1'b0;
    dmem_ren <= 1'b0;
    stalls = 0;
    // Sample mid-cycle, first completion cycle ends the wait
    @(negedge clk);
    while (dmem_stall) begin
      stalls++;
      @(negedge clk);
    end
    exp_stall = ref_access(wr, a, wdata, strb, exp_word);
    exp_data_q.push_back(exp_word);
    got_data_q.push_back(dmem_rdata);
    exp_stall_q.push_back(exp_stall);
    got_stall_q.push_back(stalls);
    is_read_q.push_back(!wr);
    addr_q.push_back(a);
    @(posedge clk);
  endtask

  task automatic end_test(input int num, input string name);
    @(negedge clk);
    $display("test %0d (%s) finished with %0d errors", num, name, errors - errs_mark);
    errs_mark = errors;
  endtask

  // Compare process, one completed access per edge
  always @(posedge clk) begin
    if (got_stall_q.size() > 0) begin
      cmp_exp_data  = exp_data_q.pop_front();
      cmp_got_data  = got_data_q.pop_front();
      cmp_exp_stall = exp_stall_q.pop_front();
      cmp_got_stall = got_stall_q.pop_front();
      cmp_is_read   = is_read_q.pop_front();
      cmp_addr      = addr_q.pop_front();
      checks++;
      if (cmp_got_stall != cmp_exp_stall) begin
        $display("[FAIL] %0t: addr %08h stalled %0d cycles, expected %0d",
                 $time, cmp_addr, cmp_got_stall, cmp_exp_stall);
        errors++;
      end
      if (cmp_is_read && cmp_got_data !== cmp_exp_data) begin
        $display("[FAIL] %0t: addr %08h read %08h, expected %08h",
                 $time, cmp_addr, cmp_got_data, cmp_exp_data);
        errors++;
      end
    end
  end

  // Run limit scaled to the worst case of every operation
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] wdata;
    logic [3:0]  strb;
    bit          wr;
    rst_n      = 1'b0;
    dmem_ren   = 1'b0;
    dmem_raddr = '0;
    dmem_we    = 1'b0;
    dmem_waddr = '0;
    dmem_wdata = '0;
    dmem_wstrb = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (dmem_stall !== 1'b0) begin
      $display("[FAIL] %0t: dmem_stall is not low after reset", $time);
      errors++;
    end

    // I/O region, full then partial writes, reads with no stall
    do_access(1'b1, 32'h8000_0010, 32'hdead_beef, 4'hf);
    do_access(1'b1, 32'h8000_00fc, 32'h0123_4567, 4'hf);
    do_access(1'b1, 32'h8000_0010, 32'h5a5a_5a5a, 4'b0101);
    do_access(1'b1, 32'h8000_00fc, 32'hc300_0000, 4'b1000);
    do_access(1'b0, 32'h8000_0010, 32'h0, 4'h0);
    do_access(1'b0, 32'h8000_00fc, 32'h0, 4'h0);
    end_test(1, "io write and read");

    // Write without allocate, then a miss, then a hit
    do_access(1'b1, 32'h0000_0040, 32'h1357_9bdf, 4'hf);
    do_access(1'b0, 32'h0000_0040, 32'h0, 4'h0);
    do_access(1'b0, 32'h0000_0040, 32'h0, 4'h0);
    end_test(2, "cache miss then hit");

    // Byte merges on a resident line
    do_access(1'b1, 32'h0000_0124, 32'h1122_3344, 4'hf);
    do_access(1'b0, 32'h0000_0124, 32'h0, 4'h0);
    do_access(1'b1, 32'h0000_0124, 32'h0000_00aa, 4'b0001);
    do_access(1'b1, 32'h0000_0124, 32'h00bb_0000, 4'b0100);
    do_access(1'b0, 32'h0000_0124, 32'h0, 4'h0);
    end_test(3, "partial write hit");

    // Index 2 shared by tags 8 and 12
    do_access(1'b1, 32'h0000_0208, 32'haaaa_0001, 4'hf);
    do_access(1'b1, 32'h0000_0308, 32'hbbbb_0002, 4'hf);
    for (int i = 0; i < 6; i++) begin
      do_access(1'b0, i[0] ? 32'h0000_0308 : 32'h0000_0208, 32'h0, 4'h0);
    end
    end_test(4, "index conflict eviction");

    // Random mix, four tags per index in the cached region
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      if (r[0]) a = {1'b1, 23'b0, r[13:8], 2'b00};
      else a = {24'b0, r[17:16], r[11:8], 2'b00};
      wr   = r[1];
      strb = r[23:20];
      // First touch of a word defines all of it
      if (!is_known(a)) begin
        wr   = 1'b1;
        strb = 4'hf;
      end
      wdata = next_rand();
      do_access(wr, a, wdata, strb);
    end
    end_test(5, "random mix");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/dmem_pkg.sv
rtl/dmem_io_ram.sv
rtl/dmem_backing_ram.sv
rtl/dmem_cache.sv
rtl/dmem_cache_bridge.sv
rtl/dmem_subsystem_top.sv
dv/dmem_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dmem_subsystem_tb
RTL_TOP   ?= dmem_subsystem_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
